/* bus_fabric.sv */
`include "soc_params.svh"

module bus_fabric import soc_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [63:0] bus_address,
    input  logic [63:0] bus_write_data,
    input  logic        bus_write_enable,
    input  logic        bus_read_enable,
    input  load_type_t  bus_read_type,
    input  logic [63:0] ram_rdata,
    input  logic [7:0]  ascii_reg,
    input  logic [7:0]  buf_rdata,
    input  logic        sector_avail,
    input  logic        sd_ready,
    output logic [63:0] bus_read_data,
    output logic        bus_read_done,
    output logic        ram_read_req,
    output logic        ram_write,
    output logic [7:0]  ram_index,
    output logic [2:0]  ram_offset,
    output load_type_t  ram_load_type,
    output logic [63:0] ram_wdata,
    output logic [8:0]  buf_index,
    output logic [31:0] sd_addr,
    output logic        sd_rd_start,
    output logic        uart_valid,
    output logic [7:0]  uart_data
);
    typedef enum logic [1:0] {IDLE, WAIT_RAM, DONE} req_state_t;

    req_state_t  state;
    dev_sel_t    dev;
    logic [7:0]  hit;
    logic [63:0] ram_addr;
    logic [63:0] buf_addr;
    logic [63:0] reg_rdata;
    logic        uart_hit;
    logic        uart_hit_d;

    // Match lines, one per device
    assign hit[0] = bus_address >= `RAM_BASE && bus_address < `RAM_BASE + `RAM_SIZE;
    assign hit[1] = bus_address == `KEY_ADDR;
    assign hit[2] = bus_address == `UART_ADDR;
    assign hit[3] = bus_address == `SD_ADDR_REG;
    assign hit[4] = bus_address == `SD_READ;
    assign hit[5] = bus_address == `SD_READY;
    assign hit[6] = bus_address == `SD_AVAIL;
    assign hit[7] = bus_address >= `SD_BUF_BASE &&
                    bus_address < `SD_BUF_BASE + `SD_SECTOR_BYTES;

    always_comb begin
        dev = DEV_NONE;
        if (hit[0])      dev = DEV_RAM;
        else if (hit[1]) dev = DEV_KEY;
        else if (hit[2]) dev = DEV_UART;
        else if (hit[3]) dev = DEV_SD_ADDR;
        else if (hit[4]) dev = DEV_SD_READ;
        else if (hit[5]) dev = DEV_SD_READY;
        else if (hit[6]) dev = DEV_SD_AVAIL;
        else if (hit[7]) dev = DEV_SD_BUF;
    end

    // Register-style reads, unmapped space reads as zero
    always_comb begin
        case (dev)
            DEV_KEY:      reg_rdata = {56'd0, ascii_reg};
            DEV_SD_ADDR:  reg_rdata = {32'd0, sd_addr};
            DEV_SD_READY: reg_rdata = {63'd0, sd_ready};
            DEV_SD_AVAIL: reg_rdata = {63'd0, sector_avail};
            DEV_SD_BUF:   reg_rdata = {56'd0, buf_rdata};
            default:      reg_rdata = 64'd0;
        endcase
    end

    assign ram_addr      = bus_address - `RAM_BASE;
    assign buf_addr      = bus_address - `SD_BUF_BASE;
    assign ram_index     = ram_addr[10:3];
    assign ram_offset    = ram_addr[2:0];
    assign ram_load_type = bus_read_type;
    assign ram_wdata     = bus_write_data;
    assign ram_write     = bus_write_enable && dev == DEV_RAM;
    assign ram_read_req  = state == IDLE && bus_read_enable && dev == DEV_RAM;
    assign buf_index     = buf_addr[8:0];

    // Four-phase read handshake
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state         <= IDLE;
            bus_read_done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (bus_read_enable && dev == DEV_RAM) begin
                        state <= WAIT_RAM;
                    end else if (bus_read_enable) begin
                        state         <= DONE;
                        bus_read_done <= 1'b1;
                    end
                end
                WAIT_RAM: begin
                    state         <= DONE;
                    bus_read_done <= 1'b1;
                end
                DONE: begin
                    if (!bus_read_enable) begin
                        state         <= IDLE;
                        bus_read_done <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == WAIT_RAM) begin
            bus_read_data <= ram_rdata;
        end else if (state == IDLE && bus_read_enable) begin
            bus_read_data <= reg_rdata;
        end
    end

    // SD control and UART edge detect
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr     <= 32'd0;
            sd_rd_start <= 1'b0;
            uart_hit_d  <= 1'b0;
        end else begin
            sd_rd_start <= bus_write_enable && dev == DEV_SD_READ;
            uart_hit_d  <= uart_hit;
            if (bus_write_enable && dev == DEV_SD_ADDR) begin
                sd_addr <= bus_write_data[31:0];
            end
        end
    end

    assign uart_hit   = bus_write_enable && dev == DEV_UART;
    assign uart_valid = uart_hit && !uart_hit_d;
    assign uart_data  = bus_write_data[7:0];

    a_done_needs_enable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(bus_read_done) |-> $past(bus_read_enable));

    a_single_device: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) |-> $onehot0(hit));

endmodule

/* data_ram.sv */
`include "soc_params.svh"

module data_ram import soc_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        ram_read_req,
    input  logic        ram_write,
    input  logic [7:0]  ram_index,
    input  logic [2:0]  ram_offset,
    input  load_type_t  ram_load_type,
    input  logic [63:0] ram_wdata,
    output logic [63:0] ram_rdata
);
    logic [63:0] mem [0:(`RAM_SIZE / 8) - 1];
    logic [63:0] shifted;
    logic [63:0] extended;

    // Bring the addressed byte lane down to bit 0
    assign shifted = mem[ram_index] >> {ram_offset, 3'b000};

    always_comb begin
        case (ram_load_type)
            LB:      extended = {{56{shifted[7]}}, shifted[7:0]};
            LH:      extended = {{48{shifted[15]}}, shifted[15:0]};
            LW:      extended = {{32{shifted[31]}}, shifted[31:0]};
            LBU:     extended = {56'd0, shifted[7:0]};
            LHU:     extended = {48'd0, shifted[15:0]};
            LWU:     extended = {32'd0, shifted[31:0]};
            default: extended = shifted;
        endcase
    end

    // Whole doubleword stores only
    always_ff @(posedge CLOCK_50) begin
        if (ram_write) begin
            mem[ram_index] <= ram_wdata;
        end
        if (ram_read_req) begin
            ram_rdata <= extended;
        end
    end

    a_half_aligned: assert property (@(posedge CLOCK_50)
        ram_read_req && ram_load_type inside {LH, LHU} |-> ram_offset[0] == 1'b0);

    a_word_aligned: assert property (@(posedge CLOCK_50)
        ram_read_req && ram_load_type inside {LW, LWU} |-> ram_offset[1:0] == 2'b00);

endmodule

/* key_irq_ctrl.sv */
module key_irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_pressed,
    input  logic [7:0] key_ascii,
    input  logic       irq_ack,
    output logic [7:0] ascii_reg,
    output logic [3:0] irq_vector
);
    logic key_pressed_d;
    logic key_edge;

    assign key_edge = key_pressed && !key_pressed_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_pressed_d <= 1'b0;
            ascii_reg     <= 8'd0;
            irq_vector    <= 4'd0;
        end else begin
            key_pressed_d <= key_pressed;
            if (key_edge) begin
                ascii_reg <= key_ascii;
            end
            // Acknowledge takes priority over a new press
            if (irq_ack) begin
                irq_vector <= 4'd0;
            end else if (key_edge && key_ascii != 8'd0) begin
                irq_vector <= 4'd1;
            end
        end
    end

endmodule

/* periph_bus.sv */
module periph_bus import soc_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [63:0] bus_address,
    input  logic [63:0] bus_write_data,
    input  logic        bus_write_enable,
    input  logic        bus_read_enable,
    input  load_type_t  bus_read_type,
    output logic [63:0] bus_read_data,
    output logic        bus_read_done,
    input  logic        key_pressed,
    input  logic [7:0]  key_ascii,
    input  logic        irq_ack,
    output logic [3:0]  irq_vector,
    input  logic [7:0]  sd_dout,
    input  logic        sd_byte_available,
    input  logic        sd_ready,
    output logic [31:0] sd_addr,
    output logic        sd_rd_start,
    output logic        uart_valid,
    output logic [7:0]  uart_data
);
    logic        ram_read_req;
    logic        ram_write;
    logic [7:0]  ram_index;
    logic [2:0]  ram_offset;
    load_type_t  ram_load_type;
    logic [63:0] ram_wdata;
    logic [63:0] ram_rdata;
    logic [7:0]  ascii_reg;
    logic [8:0]  buf_index;
    logic [7:0]  buf_rdata;
    logic        sector_avail;

    bus_fabric u_fabric (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_type    (bus_read_type),
        .ram_rdata        (ram_rdata),
        .ascii_reg        (ascii_reg),
        .buf_rdata        (buf_rdata),
        .sector_avail     (sector_avail),
        .sd_ready         (sd_ready),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .ram_read_req     (ram_read_req),
        .ram_write        (ram_write),
        .ram_index        (ram_index),
        .ram_offset       (ram_offset),
        .ram_load_type    (ram_load_type),
        .ram_wdata        (ram_wdata),
        .buf_index        (buf_index),
        .sd_addr          (sd_addr),
        .sd_rd_start      (sd_rd_start),
        .uart_valid       (uart_valid),
        .uart_data        (uart_data)
    );

    data_ram u_ram (
        .CLOCK_50      (CLOCK_50),
        .ram_read_req  (ram_read_req),
        .ram_write     (ram_write),
        .ram_index     (ram_index),
        .ram_offset    (ram_offset),
        .ram_load_type (ram_load_type),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata)
    );

    key_irq_ctrl u_key (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_pressed (key_pressed),
        .key_ascii   (key_ascii),
        .irq_ack     (irq_ack),
        .ascii_reg   (ascii_reg),
        .irq_vector  (irq_vector)
    );

    // Sector buffer restarts on the same pulse that goes to the SD controller
    sd_sector_buffer u_sd (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_rd_start       (sd_rd_start),
        .buf_index         (buf_index),
        .buf_rdata         (buf_rdata),
        .sector_avail      (sector_avail)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_periph_bus -o sim_periph_bus

status=0
./obj_dir/sim_periph_bus > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

/* sd_sector_buffer.sv */
`include "soc_params.svh"

module sd_sector_buffer (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] sd_dout,
    input  logic       sd_byte_available,
    input  logic       sd_rd_start,
    input  logic [8:0] buf_index,
    output logic [7:0] buf_rdata,
    output logic       sector_avail
);
    logic [7:0] mem [0:`SD_SECTOR_BYTES - 1];
    logic [8:0] wr_index;
    logic       byte_avail_d;
    logic       byte_edge;

    // Controller holds byte_available for several clocks per byte
    assign byte_edge = sd_byte_available && !byte_avail_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_index     <= 9'd0;
            byte_avail_d <= 1'b0;
            sector_avail <= 1'b0;
        end else begin
            byte_avail_d <= sd_byte_available;
            if (sd_rd_start) begin
                wr_index     <= 9'd0;
                sector_avail <= 1'b0;
            end else if (byte_edge) begin
                if (wr_index == `SD_SECTOR_BYTES - 1) begin
                    wr_index     <= 9'd0;
                    sector_avail <= 1'b1;
                end else begin
                    wr_index <= wr_index + 9'd1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_edge && !sd_rd_start) begin
            mem[wr_index] <= sd_dout;
        end
    end

    // Combinational read port for the fabric
    assign buf_rdata = mem[buf_index];

    // A new byte in the restart cycle would be lost and shift the sector
    a_no_byte_on_restart: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |-> !byte_edge);

endmodule

/* soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Data RAM window
`define RAM_BASE        64'h0000_0000_0000_1000
`define RAM_SIZE        64'd2048

// Keyboard and UART registers
`define KEY_ADDR        64'h0000_0000_0000_0100
`define UART_ADDR       64'h0000_0000_0000_0108

// SD controller registers
`define SD_ADDR_REG     64'h0000_0000_0000_0110
`define SD_READ         64'h0000_0000_0000_0118
`define SD_READY        64'h0000_0000_0000_0120
`define SD_AVAIL        64'h0000_0000_0000_0128

// SD sector buffer, one byte per address
`define SD_BUF_BASE     64'h0000_0000_0000_2000
`define SD_SECTOR_BYTES 64'd512

`endif

/* soc_pkg.sv */
package soc_pkg;

    // RISC-V load funct3 encodings
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } load_type_t;

    // Device picked by the address decoder
    typedef enum logic [3:0] {
        DEV_NONE     = 4'd0,
        DEV_RAM      = 4'd1,
        DEV_KEY      = 4'd2,
        DEV_UART     = 4'd3,
        DEV_SD_ADDR  = 4'd4,
        DEV_SD_READ  = 4'd5,
        DEV_SD_READY = 4'd6,
        DEV_SD_AVAIL = 4'd7,
        DEV_SD_BUF   = 4'd8
    } dev_sel_t;

endpackage

/* sources.f */
+incdir+.
soc_pkg.sv
bus_fabric.sv
data_ram.sv
key_irq_ctrl.sv
sd_sector_buffer.sv
periph_bus.sv
tb_periph_bus.sv

/* tb_periph_bus.sv */
`include "soc_params.svh"

module tb_periph_bus import soc_pkg::*; ();
    localparam int max_records = 64;
    localparam int sector_len = 512;

    logic        CLOCK_50;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    load_type_t  bus_read_type;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic        key_pressed;
    logic [7:0]  key_ascii;
    logic        irq_ack;
    logic [3:0]  irq_vector;
    logic [7:0]  sd_dout;
    logic        sd_byte_available;
    logic        sd_ready;
    logic [31:0] sd_addr;
    logic        sd_rd_start;
    logic        uart_valid;
    logic [7:0]  uart_data;

    logic [63:0] stim [0:max_records * 5 - 1];
    logic [63:0] shadow [0:255];
    logic [7:0]  sector_bytes [0:sector_len - 1];
    integer      seed;
    int          data_errors = 0;
    int          flag_errors = 0;
    int          vec_errors = 0;
    int          other_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 40000;
    int          uart_pulses = 0;
    logic [7:0]  uart_byte = 8'd0;

    periph_bus u_periph_bus (.*);

    always #50 CLOCK_50 = ~CLOCK_50;

    // Watchdog
    always @(posedge CLOCK_50) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, a bus or stream step never finished",
                     cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // UART receiver samples on the rising edge
    always @(posedge CLOCK_50) begin
        if (uart_valid) begin
            uart_pulses++;
            uart_byte = uart_data;
        end
    end

    task automatic check_data(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            flag_errors++;
        end
    endtask

    task automatic check_vec(input string name, input logic [3:0] got,
                             input logic [3:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            vec_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        other_errors++;
    endtask

    function automatic dev_sel_t decode_addr(input logic [63:0] a);
        dev_sel_t d;
        d = DEV_NONE;
        if (a >= `RAM_BASE && a < `RAM_BASE + `RAM_SIZE)
            d = DEV_RAM;
        else if (a == `KEY_ADDR)
            d = DEV_KEY;
        else if (a == `UART_ADDR)
            d = DEV_UART;
        else if (a == `SD_ADDR_REG)
            d = DEV_SD_ADDR;
        else if (a == `SD_READ)
            d = DEV_SD_READ;
        else if (a == `SD_READY)
            d = DEV_SD_READY;
        else if (a == `SD_AVAIL)
            d = DEV_SD_AVAIL;
        else if (a >= `SD_BUF_BASE && a < `SD_BUF_BASE + `SD_SECTOR_BYTES)
            d = DEV_SD_BUF;
        return d;
    endfunction

    // Little-endian byte model of a sized load with sign fill
    function automatic logic [63:0] load_expect(input logic [63:0] dw, input logic [2:0] off,
                                                input load_type_t t);
        logic [63:0] res;
        logic [7:0]  fill;
        int          nbytes;
        int          pos;
        int          i;
        case (t)
            LB, LBU: nbytes = 1;
            LH, LHU: nbytes = 2;
            LW, LWU: nbytes = 4;
            default: nbytes = 8;
        endcase
        res = 64'd0;
        for (i = 0; i < nbytes; i++) begin
            pos = int'(off) + i;
            if (pos < 8) begin
                res[i * 8 +: 8] = dw[pos * 8 +: 8];
            end
        end
        fill = 8'h00;
        if ((t == LB || t == LH || t == LW) && res[nbytes * 8 - 1]) begin
            fill = 8'hFF;
        end
        for (i = nbytes; i < 8; i++) begin
            res[i * 8 +: 8] = fill;
        end
        return res;
    endfunction

    // All bus tasks start and end on a falling edge
    task automatic do_write(input logic [63:0] addr, input logic [63:0] data);
        dev_sel_t    dev;
        logic [63:0] offs;
        dev = decode_addr(addr);
        bus_address = addr;
        bus_write_data = data;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        if (dev == DEV_RAM) begin
            offs = addr - `RAM_BASE;
            shadow[offs[10:3]] = data;
        end else if (dev == DEV_SD_ADDR) begin
            check_data("sd_addr", {32'd0, sd_addr}, {32'd0, data[31:0]});
        end else if (dev == DEV_SD_READ) begin
            check_flag("sd_rd_start", sd_rd_start, 1'b1);
            @(negedge CLOCK_50);
            check_flag("sd_rd_start", sd_rd_start, 1'b0);
        end
    endtask

    task automatic do_read(input logic [63:0] addr, input load_type_t typ, input int hold,
                           input logic [63:0] exp_file);
        dev_sel_t    dev;
        logic [63:0] offs;
        logic [63:0] exp;
        int          waited;
        int          latency;
        dev = decode_addr(addr);
        exp = exp_file;
        latency = (dev == DEV_RAM) ? 2 : 1;
        if (dev == DEV_RAM) begin
            offs = addr - `RAM_BASE;
            exp = load_expect(shadow[offs[10:3]], offs[2:0], typ);
            if (exp !== exp_file) begin
                report_problem($sformatf("stim value for %h does not match the load model",
                                         addr));
            end
        end else if (dev == DEV_SD_BUF) begin
            offs = addr - `SD_BUF_BASE;
            exp = {56'd0, sector_bytes[offs[8:0]]};
        end
        bus_address = addr;
        bus_read_type = typ;
        bus_read_enable = 1'b1;
        waited = 0;
        do begin
            @(negedge CLOCK_50);
            waited++;
        end while (!bus_read_done);
        if (waited != latency) begin
            report_problem($sformatf("read of %h took %0d cycles instead of %0d",
                                     addr, waited, latency));
        end
        check_data("bus_read_data", bus_read_data, exp);
        // Done and data hold while the master keeps enable high
        repeat (hold) begin
            @(negedge CLOCK_50);
            check_flag("bus_read_done", bus_read_done, 1'b1);
            check_data("bus_read_data", bus_read_data, exp);
        end
        bus_read_enable = 1'b0;
        @(negedge CLOCK_50);
        check_flag("bus_read_done", bus_read_done, 1'b0);
    endtask

    task automatic press_key(input logic [7:0] code, input logic [3:0] exp);
        key_ascii = code;
        key_pressed = 1'b1;
        @(negedge CLOCK_50);
        // Vector follows one cycle after the press
        check_vec("irq_vector", irq_vector, exp);
        key_pressed = 1'b0;
        @(negedge CLOCK_50);
        check_vec("irq_vector", irq_vector, exp);
    endtask

    task automatic ack_irq(input logic [3:0] exp);
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        check_vec("irq_vector", irq_vector, exp);
        irq_ack = 1'b0;
        @(negedge CLOCK_50);
        check_vec("irq_vector", irq_vector, exp);
    endtask

    task automatic stream_sector(input logic ready_after);
        logic [31:0] rnd;
        int          i;
        for (i = 0; i < sector_len; i++) begin
            rnd = $random(seed);
            sector_bytes[i] = rnd[7:0];
            sd_dout = rnd[7:0];
            sd_byte_available = 1'b1;
            repeat (2) @(negedge CLOCK_50);
            sd_byte_available = 1'b0;
            // Gap of one to four idle cycles
            repeat (1 + int'(rnd[9:8])) @(negedge CLOCK_50);
        end
        sd_ready = ready_after;
        @(negedge CLOCK_50);
    endtask

    task automatic check_uart(input logic [63:0] addr, input logic [63:0] data,
                              input logic [7:0] exp);
        int start;
        start = uart_pulses;
        do_write(addr, data);
        repeat (3) @(negedge CLOCK_50);
        if (uart_pulses - start != 1) begin
            report_problem($sformatf("uart_valid pulsed %0d times for one write",
                                     uart_pulses - start));
        end
        check_data("uart_data", {56'd0, uart_byte}, {56'd0, exp});
    endtask

    task automatic run_record(input int r);
        logic [63:0] op;
        logic [63:0] addr;
        logic [63:0] data;
        logic [63:0] typ;
        logic [63:0] exp;
        op = stim[r * 5];
        addr = stim[r * 5 + 1];
        data = stim[r * 5 + 2];
        typ = stim[r * 5 + 3];
        exp = stim[r * 5 + 4];
        case (op)
            64'd1: do_write(addr, data);
            64'd2: do_read(addr, load_type_t'(typ[2:0]), int'(data[7:0]), exp);
            64'd3: press_key(data[7:0], exp[3:0]);
            64'd4: ack_irq(exp[3:0]);
            64'd5: stream_sector(data[0]);
            64'd6: check_uart(addr, data, exp[7:0]);
            default: report_problem($sformatf("record %0d has unknown op %h", r, op));
        endcase
    endtask

    initial begin
        int n;
        int r;
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        bus_address = 64'd0;
        bus_write_data = 64'd0;
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        bus_read_type = LD;
        key_pressed = 1'b0;
        key_ascii = 8'd0;
        irq_ack = 1'b0;
        sd_dout = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready = 1'b0;
        seed = 84199;
        for (r = 0; r < max_records * 5; r++) begin
            stim[r] = 64'd0;
        end
        $readmemh("tb_stim.txt", stim);
        // Op zero marks the end of the records
        n = 0;
        while (n < max_records && stim[n * 5] != 64'd0) begin
            n++;
        end
        if (n == 0) begin
            report_problem("no stimulus records were read");
        end
        cycle_limit = 20 * n + 40000;

        repeat (5) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        check_flag("bus_read_done", bus_read_done, 1'b0);
        check_flag("uart_valid", uart_valid, 1'b0);
        check_flag("sd_rd_start", sd_rd_start, 1'b0);
        check_vec("irq_vector", irq_vector, 4'd0);

        for (r = 0; r < n; r++) begin
            run_record(r);
        end

        $display("errors: data %0d flag %0d vec %0d other %0d",
                 data_errors, flag_errors, vec_errors, other_errors);
        if (data_errors + flag_errors + vec_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb_stim.txt */
// op addr data type expected, all hex
// op 1 write, 2 read (data = extra hold cycles), 3 key press, 4 irq ack, 5 sector, 6 uart
2 128 0 3 0
1 1008 F1E2D3C4B5A69788 0 0
1 1010 0123456789ABCDEF 0 0
2 1008 0 3 F1E2D3C4B5A69788
2 1008 0 0 FFFFFFFFFFFFFF88
2 1008 0 4 0000000000000088
2 100B 0 0 FFFFFFFFFFFFFFB5
2 100D 0 4 00000000000000D3
2 100A 0 1 FFFFFFFFFFFFB5A6
2 100E 0 5 000000000000F1E2
2 1008 0 2 FFFFFFFFB5A69788
2 100C 0 6 00000000F1E2D3C4
2 100C 0 2 FFFFFFFFF1E2D3C4
2 1017 0 0 0000000000000001
2 1014 0 1 0000000000004567
2 1014 0 2 0000000001234567
2 1010 5 3 0123456789ABCDEF
2 300 3 3 0
2 1800 0 3 0
3 0 41 0 1
2 100 0 3 41
4 0 0 0 0
3 0 0 0 0
2 100 0 3 0
3 0 5A 0 1
4 0 0 0 0
6 108 1234567890ABCD5A 0 5A
1 110 00000000CAFE0042 0 0
2 110 0 3 00000000CAFE0042
2 120 0 3 0
1 118 1 0 0
2 128 0 3 0
5 0 1 0 0
2 128 0 3 1
2 120 0 3 1
2 2000 0 3 0
2 2001 2 3 0
2 20A7 0 3 0
2 21FF 0 3 0
1 118 1 0 0
2 128 0 3 0
